/* bench/scale_space_stimulus.txt */
// per row, line 1: image row, expected blurred row, expected keypoint mask
// line 2: blur levels 0, 1, 2 and 3 of that row; column 0 is the rightmost byte
110780010000ff10 120430010400af0b c3
43ff31465042434d 43ff3b464842434a 4000404040404040 40004a3a4040403d
220700020000ff10 220620021000ef0f 80
44ff31464142404d 44ff3b464142404a 4000404040404040 40004a3a4040403d
330700034000ff10 330708031800ff10 82
45ff31465042434d 45ff3b464842434a 4000404040404040 40004a3a4040403d
440700040000ff10 440708041000ff10 80
460031464142404d 46003b464142404a 40ff404040404040 40ff4a3a4040403d
550700050000ff10 4d0620040400ef0f ca
47ff31464f42434d 47ff3b464842434a 4000404040404040 40004a3a4040403d
660780060000ff10 3f0430030000af0b 90
48ff31474142404d 48ff3b474142404a 4000404040404040 40004a3a4040403d

/* compile.f */
+incdir+include
hw/sift_pkg.sv
hw/scale_space_ctrl.sv
hw/line_buffer.sv
hw/gaussian_column_filter.sv
hw/dog_extrema_detector.sv
hw/scale_space_top.sv
bench/scale_space_tb.sv

/* Bender.yml */
package:
  name: scale_space

sources:
  - hw/sift_pkg.sv
  - hw/scale_space_ctrl.sv
  - hw/line_buffer.sv
  - hw/gaussian_column_filter.sv
  - hw/dog_extrema_detector.sv
  - hw/scale_space_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/scale_space_tb.sv

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==============================
// checks shared by the testbench
// ==============================

// 32-bit linear congruential step, numerical recipes constants.
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic report_fatal(input string msg);
  $display("%s", msg);
  $display("Finished with errors");
  $fatal(1, msg);
endtask

// values up to one row wide.
task automatic check_equal(
  input logic [63:0] actual,
  input logic [63:0] expected,
  input string       msg
);
  if (actual !== expected) begin
    $display("mismatch at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
    report_fatal(msg);
  end
endtask

`endif

/* bench/scale_space_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module scale_space_tb;

  localparam int HEIGHT         = 6;
  localparam int FRAMES         = 2;
  localparam int FRAME_CYCLES   = 2 * (2 * HEIGHT + 10);
  localparam int TIMEOUT_CYCLES = FRAME_CYCLES * FRAMES;
  localparam int WORDS_PER_ROW  = 7;                 // image, blur, mask, four levels.
  localparam int STIM_WORDS     = WORDS_PER_ROW * HEIGHT;
  localparam int FIRST_REQ      = 1;                 // cycles after the start pulse.
  localparam int BLUR_LAT       = 4;
  localparam int KP_LAT         = 2;
  localparam int DETECT_START   = FIRST_REQ + HEIGHT + 2;
  localparam int FRAME_SPAN     = DETECT_START + HEIGHT + KP_LAT + 1;

  logic                 clk;
  logic                 rst_n;
  logic                 start;
  sift_pkg::row_t       img_row;
  sift_pkg::row_t [3:0] blur_rows;
  logic                 row_req;
  logic                 blur_req;
  sift_pkg::row_t       blur_row;
  logic                 blur_valid;
  sift_pkg::kp_mask_t   kp_mask;
  logic                 kp_valid;
  logic                 done;

  logic [63:0] stim_mem [0:STIM_WORDS-1];
  logic [31:0] lcg_state   = 32'ha8f9_29bd;
  int          cycle_count = 0;

  `include "tb_checks.svh"

  scale_space_top #(
    .HEIGHT        (HEIGHT),
    .DOG_THRESHOLD (2)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .img_row    (img_row),
    .blur_rows  (blur_rows),
    .row_req    (row_req),
    .blur_req   (blur_req),
    .blur_row   (blur_row),
    .blur_valid (blur_valid),
    .kp_mask    (kp_mask),
    .kp_valid   (kp_valid),
    .done       (done)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_fatal($sformatf("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // ==============================
  // stimulus helpers
  // ==============================
  task automatic random_row(output sift_pkg::row_t r);
    logic [31:0] hi;
    lcg_state = lcg_next(lcg_state);
    hi        = lcg_state;
    lcg_state = lcg_next(lcg_state);
    r         = {hi, lcg_state};
  endtask

  task automatic drive_junk_blur();
    sift_pkg::row_t junk;
    for (int l = 0; l < 4; l++) begin
      random_row(junk);
      blur_rows[l] = junk;
    end
  endtask

  task automatic idle_cycles(input int n, input string where);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #2;
      check_equal(row_req, 1'b0, {where, " row_req"});
      check_equal(blur_req, 1'b0, {where, " blur_req"});
      check_equal(blur_valid, 1'b0, {where, " blur_valid"});
      check_equal(kp_valid, 1'b0, {where, " kp_valid"});
      check_equal(done, 1'b0, {where, " done"});
      start = 1'b0;
      random_row(img_row);                           // ignored while idle.
      drive_junk_blur();
    end
  endtask

  // k counts cycles from the start pulse.
  task automatic check_cycle(input int frame, input int k);
    string tag;
    int    blur_idx;
    int    kp_idx;
    tag      = $sformatf("frame %0d cycle %0d", frame, k);
    blur_idx = k - FIRST_REQ - BLUR_LAT;
    kp_idx   = k - DETECT_START - KP_LAT;
    check_equal(row_req, (k >= FIRST_REQ && k < FIRST_REQ + HEIGHT), {tag, " row_req"});
    check_equal(blur_req, (k >= DETECT_START && k < DETECT_START + HEIGHT), {tag, " blur_req"});
    check_equal(done, (k == DETECT_START + HEIGHT), {tag, " done"});
    check_equal(blur_valid, (blur_idx >= 0 && blur_idx < HEIGHT), {tag, " blur_valid"});
    check_equal(kp_valid, (kp_idx >= 0 && kp_idx < HEIGHT), {tag, " kp_valid"});
    if (blur_idx >= 0 && blur_idx < HEIGHT) begin
      check_equal(blur_row, stim_mem[WORDS_PER_ROW * blur_idx + 1],
                  $sformatf("%s blur_row %0d", tag, blur_idx));
    end
    if (kp_idx >= 0 && kp_idx < HEIGHT) begin
      check_equal(kp_mask, stim_mem[WORDS_PER_ROW * kp_idx + 2],
                  $sformatf("%s kp_mask %0d", tag, kp_idx));
    end
  endtask

  // ==============================
  // one frame, memories answer the strobes
  // ==============================
  task automatic run_frame(input int frame, input int restart_k);
    int img_idx;
    int lvl_idx;
    img_idx = 0;
    lvl_idx = 0;
    for (int k = 0; k <= FRAME_SPAN; k++) begin
      @(posedge clk);
      #2;
      check_cycle(frame, k);
      start = (k == 0) || (k == restart_k);          // second pulse lands mid-frame.
      if (row_req) begin
        img_row = stim_mem[WORDS_PER_ROW * img_idx];
        img_idx++;
      end else begin
        random_row(img_row);
      end
      if (blur_req) begin
        for (int l = 0; l < 4; l++) begin
          blur_rows[l] = stim_mem[WORDS_PER_ROW * lvl_idx + 3 + l];
        end
        lvl_idx++;
      end else begin
        drive_junk_blur();
      end
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    start     = 1'b0;
    img_row   = '0;
    blur_rows = '0;
    $readmemh("bench/scale_space_stimulus.txt", stim_mem);
    if ($isunknown(stim_mem[STIM_WORDS-1])) begin
      report_fatal("stimulus file bench/scale_space_stimulus.txt is missing or too short");
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    idle_cycles(4, "after reset");
    run_frame(1, FIRST_REQ + 3);
    idle_cycles(2, "between frames");
    run_frame(2, DETECT_START + 2);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/scale_space_top.sv */
`timescale 1ns/10ps
`default_nettype none

module scale_space_top #(
  parameter int             HEIGHT        = 6,
  parameter sift_pkg::dog_t DOG_THRESHOLD = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  sift_pkg::row_t       img_row,
  input  sift_pkg::row_t [3:0] blur_rows,
  output logic                 row_req,
  output logic                 blur_req,
  output sift_pkg::row_t       blur_row,
  output logic                 blur_valid,
  output sift_pkg::kp_mask_t   kp_mask,
  output logic                 kp_valid,
  output logic                 done
);

  sift_pkg::buffer_ctrl_t buf_ctrl;
  sift_pkg::line_window_t window;

  scale_space_ctrl #(
    .HEIGHT (HEIGHT)
  ) u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .ctrl     (buf_ctrl),
    .row_req  (row_req),
    .blur_req (blur_req),
    .done     (done)
  );

  line_buffer u_line_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (buf_ctrl),
    .img_row   (img_row),
    .blur_rows (blur_rows),
    .window    (window)
  );

  // row_req doubles as the row-entry strobe.
  gaussian_column_filter u_gaussian (
    .clk        (clk),
    .rst_n      (rst_n),
    .window     (window),
    .row_in     (row_req),
    .blur_row   (blur_row),
    .blur_valid (blur_valid)
  );

  dog_extrema_detector #(
    .DOG_THRESHOLD (DOG_THRESHOLD)
  ) u_detector (
    .clk      (clk),
    .rst_n    (rst_n),
    .window   (window),
    .row_in   (blur_req),
    .kp_mask  (kp_mask),
    .kp_valid (kp_valid)
  );

endmodule

`default_nettype wire

/* hw/dog_extrema_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module dog_extrema_detector #(
  parameter sift_pkg::dog_t DOG_THRESHOLD = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  sift_pkg::line_window_t window,
  input  logic                   row_in,
  output sift_pkg::kp_mask_t     kp_mask,
  output logic                   kp_valid
);

  logic               row_d;                    // even slots hold a fresh row.
  logic               row_dd;
  logic               first_row;
  sift_pkg::kp_mask_t mask_next;

  function automatic sift_pkg::dog_t dog(input sift_pkg::pix_t a, input sift_pkg::pix_t b);
    return $signed({1'b0, a}) - $signed({1'b0, b});
  endfunction

  // odd slots still carry gaussian data on the first detect row.
  assign first_row = row_d && !row_dd;

  // ==============================
  // per-column maximum
  // ==============================
  always_comb begin
    sift_pkg::dog_t d0;
    sift_pkg::dog_t d1;
    sift_pkg::dog_t d2;
    sift_pkg::dog_t d1_prev;
    for (int c = 0; c < sift_pkg::COLS; c++) begin
      d0      = dog(window.slot_2[c], window.slot_4[c]);
      d1      = dog(window.slot_4[c], window.slot_6[c]);
      d2      = dog(window.slot_6[c], window.slot_8[c]);
      d1_prev = first_row ? '0 : dog(window.slot_5[c], window.slot_7[c]);
      mask_next[c] = (d1 > d0) && (d1 > d2) && (d1 > d1_prev) && (d1 > DOG_THRESHOLD);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_d    <= 1'b0;
      row_dd   <= 1'b0;
      kp_valid <= 1'b0;
    end else begin
      row_d    <= row_in;
      row_dd   <= row_d;
      kp_valid <= row_d;
    end
  end

  always_ff @(posedge clk) begin
    if (row_d) begin
      kp_mask <= mask_next;
    end
  end

endmodule

`default_nettype wire

/* hw/gaussian_column_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module gaussian_column_filter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  sift_pkg::line_window_t window,
  input  logic                   row_in,
  output sift_pkg::row_t         blur_row,
  output logic                   blur_valid
);

  logic [2:0]     row_pipe;                     // bit 2 set while slot 2 is a real row.
  sift_pkg::row_t blur_next;

  // 1 4 6 4 1 over five rows, divided by 16 and truncated.
  function automatic sift_pkg::pix_t blur_pixel(
    input sift_pkg::pix_t p0,
    input sift_pkg::pix_t p1,
    input sift_pkg::pix_t p2,
    input sift_pkg::pix_t p3,
    input sift_pkg::pix_t p4
  );
    logic [sift_pkg::PIX_W+3:0] sum;
    sum = {4'd0, p0} + ({4'd0, p1} << 2) + ({4'd0, p2} << 2) + ({4'd0, p2} << 1)
        + ({4'd0, p3} << 2) + {4'd0, p4};
    return sum[sift_pkg::PIX_W+3:4];
  endfunction

  always_comb begin
    for (int c = 0; c < sift_pkg::COLS; c++) begin
      blur_next[c] = blur_pixel(window.slot_0[c], window.slot_1[c], window.slot_2[c],
                                window.slot_3[c], window.slot_4[c]);
    end
  end

  // ==============================
  // registers
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_pipe   <= '0;
      blur_valid <= 1'b0;
    end else begin
      row_pipe   <= {row_pipe[1:0], row_in};
      blur_valid <= row_pipe[2];
    end
  end

  always_ff @(posedge clk) begin
    if (row_pipe[2]) begin
      blur_row <= blur_next;
    end
  end

endmodule

`default_nettype wire

/* hw/line_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module line_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  sift_pkg::buffer_ctrl_t ctrl,
  input  sift_pkg::row_t         img_row,
  input  sift_pkg::row_t [3:0]   blur_rows,
  output sift_pkg::line_window_t window
);

  // ==============================
  // image slots 0 and 1
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      window.slot_0 <= '0;
      window.slot_1 <= '0;
    end else begin
      case (ctrl.mode)
        sift_pkg::sys_idle: begin
          window.slot_0 <= '0;
          window.slot_1 <= '0;
        end
        sift_pkg::sys_gaussian: begin
          if (ctrl.we) begin
            window.slot_0 <= img_row;
          end else if (ctrl.fill_zero) begin
            window.slot_0 <= '0;                // zero row below the image.
          end
          window.slot_1 <= window.slot_0;
        end
        sift_pkg::sys_detect_filter: begin
          if (ctrl.we) begin
            window.slot_0 <= img_row;           // unused by the detector.
            window.slot_1 <= window.slot_0;
          end
        end
        default: ;
      endcase
    end
  end

  // ==============================
  // slots 2 to 9
  // ==============================
  // gaussian shifts 2..5 as one column while detect pairs each level with its previous row.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      window.slot_2 <= '0;
      window.slot_3 <= '0;
      window.slot_4 <= '0;
      window.slot_5 <= '0;
      window.slot_6 <= '0;
      window.slot_7 <= '0;
      window.slot_8 <= '0;
      window.slot_9 <= '0;
    end else begin
      case (ctrl.mode)
        sift_pkg::sys_idle: begin
          window.slot_2 <= '0;
          window.slot_3 <= '0;
          window.slot_4 <= '0;
          window.slot_5 <= '0;
          window.slot_6 <= '0;
          window.slot_7 <= '0;
          window.slot_8 <= '0;
          window.slot_9 <= '0;
        end
        sift_pkg::sys_gaussian: begin
          window.slot_2 <= window.slot_1;
          window.slot_3 <= window.slot_2;
          window.slot_4 <= window.slot_3;
          window.slot_5 <= window.slot_4;
        end
        sift_pkg::sys_detect_filter: begin
          if (ctrl.we) begin
            window.slot_2 <= blur_rows[0];
            window.slot_3 <= window.slot_2;
            window.slot_4 <= blur_rows[1];
            window.slot_5 <= window.slot_4;
            window.slot_6 <= blur_rows[2];
            window.slot_7 <= window.slot_6;
            window.slot_8 <= blur_rows[3];
            window.slot_9 <= window.slot_8;
          end
        end
        default: ;                              // end marker holds.
      endcase
    end
  end

  a_mode_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    ctrl.mode inside {sift_pkg::sys_idle, sift_pkg::sys_gaussian,
                      sift_pkg::sys_detect_filter, sift_pkg::sys_end});

  // a pad row would be lost behind the image load.
  a_no_fill_on_write: assert property (
    @(posedge clk) disable iff (!rst_n) !(ctrl.we && ctrl.fill_zero));

endmodule

`default_nettype wire

/* hw/scale_space_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module scale_space_ctrl #(
  parameter int HEIGHT = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  output sift_pkg::buffer_ctrl_t ctrl,
  output logic                   row_req,
  output logic                   blur_req,
  output logic                   done
);

  // sized for image rows plus two padding rows.
  localparam int CNT_W = $clog2(HEIGHT + 2);

  sift_pkg::sys_mode_t state;
  logic [CNT_W-1:0]    row_cnt;                 // restarts at each phase entry.

  // ==============================
  // phase state machine
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= sift_pkg::sys_idle;
      row_cnt <= '0;
    end else begin
      case (state)
        sift_pkg::sys_idle: begin
          if (start) begin
            state   <= sift_pkg::sys_gaussian;
            row_cnt <= '0;
          end
        end
        sift_pkg::sys_gaussian: begin
          if (row_cnt == CNT_W'(HEIGHT + 1)) begin
            state   <= sift_pkg::sys_detect_filter;
            row_cnt <= '0;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        sift_pkg::sys_detect_filter: begin
          if (row_cnt == CNT_W'(HEIGHT - 1)) begin
            state   <= sift_pkg::sys_end;
            row_cnt <= '0;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        default: begin
          state   <= sift_pkg::sys_idle;        // end marker lasts one cycle.
          row_cnt <= '0;
        end
      endcase
    end
  end

  // ==============================
  // strobes
  // ==============================
  assign row_req  = (state == sift_pkg::sys_gaussian) && (row_cnt < CNT_W'(HEIGHT));
  assign blur_req = (state == sift_pkg::sys_detect_filter);
  assign done     = (state == sift_pkg::sys_end);

  always_comb begin
    ctrl.mode      = state;
    ctrl.we        = row_req || blur_req;
    ctrl.fill_zero = (state == sift_pkg::sys_gaussian) && !row_req;
  end

  // a restart would show up as a fresh gaussian entry.
  a_start_ignored: assert property (
    @(posedge clk) disable iff (!rst_n)
    (start && state != sift_pkg::sys_idle)
      |=> !(state == sift_pkg::sys_gaussian && row_cnt == '0));

endmodule

`default_nettype wire

/* hw/sift_pkg.sv */
`default_nettype none

package sift_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int COLS  = 8;                     // pixels per row.
  localparam int PIX_W = 8;

  typedef logic [PIX_W-1:0]        pix_t;
  typedef pix_t [COLS-1:0]         row_t;       // column c sits at row[c].
  typedef logic signed [PIX_W:0]   dog_t;       // one extra bit for the sign.
  typedef logic [COLS-1:0]         kp_mask_t;

  // ==============================
  // system modes
  // ==============================
  // encodings follow the full engine, value 3 is the match phase.
  typedef enum logic [2:0] {
    sys_idle          = 3'd0,
    sys_gaussian      = 3'd1,
    sys_detect_filter = 3'd2,
    sys_end           = 3'd4
  } sys_mode_t;

  typedef struct packed {
    sys_mode_t mode;
    logic      we;
    logic      fill_zero;                       // gaussian only, pads rows below the image.
  } buffer_ctrl_t;

  // slot_0 holds the newest row.
  typedef struct packed {
    row_t slot_9;
    row_t slot_8;
    row_t slot_7;
    row_t slot_6;
    row_t slot_5;
    row_t slot_4;
    row_t slot_3;
    row_t slot_2;
    row_t slot_1;
    row_t slot_0;
  } line_window_t;

endpackage

`default_nettype wire
